/* design/turf_game_fsm.sv */
module turf_game_fsm
  import turf_pkg::*;
(
  input  logic       CLOCK_50,
  input  logic       rst_n,
  input  logic [4:0] key_code,
  input  logic       running,
  input  logic       sweep_done,
  input  logic       hold_done,
  output plot_cmd_e  cmd,
  output logic       sweep_white,
  output logic       game_started
);

  game_state_e state;
  game_state_e state_next;

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      state <= idle;
    else
      state <= state_next;
  end

  // Next-state table
  always_comb
  begin
    state_next = state;
    case (state)
      idle:
      begin
        if (key_code == key_space)
          state_next = clear_plot;
      end

      // Start sweep in black, one pixel per plot/hold/step round
      clear_plot: state_next = clear_hold;
      clear_hold: state_next = hold_done ? clear_step : clear_hold;
      clear_step: state_next = sweep_done ? draw_p1 : clear_plot;

      // Game frame
      draw_p1:    state_next = draw_p2;
      draw_p2:    state_next = draw_p3;
      draw_p3:    state_next = draw_p4;
      draw_p4:    state_next = draw_timer;
      draw_timer: state_next = running ? draw_p1 : end_plot;

      // End sweep in white
      end_plot:   state_next = end_hold;
      end_hold:   state_next = hold_done ? end_step : end_hold;
      end_step:   state_next = sweep_done ? game_over : end_plot;

      game_over:  state_next = game_over; // Parked until reset
      default:    state_next = idle;
    endcase
  end

  // One command per state
  always_comb
  begin
    case (state)
      clear_plot,
      end_plot:   cmd = cmd_clear_plot;
      clear_hold,
      end_hold:   cmd = cmd_clear_hold;
      clear_step,
      end_step:   cmd = cmd_clear_step;
      draw_p1:    cmd = cmd_p1;
      draw_p2:    cmd = cmd_p2;
      draw_p3:    cmd = cmd_p3;
      draw_p4:    cmd = cmd_p4;
      draw_timer: cmd = cmd_timer;
      default:    cmd = cmd_none;
    endcase
  end

  assign sweep_white = state inside {end_plot, end_hold, end_step};

  // Everything from the first frame on, including the end sweep
  assign game_started = state inside {draw_p1, draw_p2, draw_p3, draw_p4, draw_timer,
                                      end_plot, end_hold, end_step, game_over};

  // Game over is terminal
  a_game_over_sticky: assert property (
    @(posedge CLOCK_50) disable iff (!rst_n)
    state == game_over |=> state == game_over
  );

endmodule

/* design/turf_game_timer.sv */
module turf_game_timer
  import turf_pkg::*;
(
  input  logic       CLOCK_50,
  input  logic       rst_n,
  input  logic       timer_tick,
  input  logic       game_started,
  output logic [7:0] bar_x,
  output logic       running
);

  logic started_seen; // Game start already taken

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bar_x        <= '0;
      running      <= 1'b0;
      started_seen <= 1'b0;
    end
    else if (game_started)
    begin
      started_seen <= 1'b1;
      if (!started_seen)
        running <= 1'b1;
      if (timer_tick)
      begin
        bar_x <= bar_x + 8'd1;
        // Old bar position decides the end of the game
        if (bar_x >= timer_last_x)
          running <= 1'b0;
      end
    end
  end

  // One game per reset
  a_running_no_restart: assert property (
    @(posedge CLOCK_50) disable iff (!rst_n)
    (game_started && started_seen && !running) |=> !running
  );

endmodule

/* design/turf_pixel_unit.sv */
module turf_pixel_unit
  import turf_pkg::*;
(
  input  logic             CLOCK_50,
  input  logic             rst_n,
  input  plot_cmd_e        cmd,
  input  logic             sweep_white,
  input  coord_t     [3:0] player_pos,
  input  logic       [7:0] bar_x,
  output pixel_t           pixel,
  output logic             plot,
  output logic             sweep_done,
  output logic             hold_done
);

  coord_t              sweep_addr;
  logic   [hold_w-1:0] hold_cnt;
  pixel_t              pixel_d;
  logic                plot_d;

  // Step from the last address ends the sweep
  assign sweep_done = (sweep_addr == sweep_last);
  assign hold_done  = (hold_cnt == '0);

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sweep_addr <= '0;
      hold_cnt   <= '0;
    end
    else
    begin
      case (cmd)
        cmd_clear_plot: hold_cnt <= hold_w'(clear_hold_cycles);
        cmd_clear_hold:
        begin
          if (!hold_done)
            hold_cnt <= hold_cnt - hold_w'(1);
        end
        cmd_clear_step:
        begin
          if (sweep_done)
            sweep_addr <= '0; // Ready for the next sweep
          else
            sweep_addr <= coord_t'(sweep_addr + 15'd1); // y inner, x outer
        end
        default: ;
      endcase
    end
  end

  // Coordinate and colour select
  always_comb
  begin
    pixel_d = '0;
    plot_d  = 1'b1;
    case (cmd)
      cmd_clear_plot:
      begin
        pixel_d.pos    = sweep_addr;
        pixel_d.colour = sweep_white ? colour_white : colour_black;
      end
      cmd_p1:    pixel_d = '{pos: player_pos[0], colour: colour_p1};
      cmd_p2:    pixel_d = '{pos: player_pos[1], colour: colour_p2};
      cmd_p3:    pixel_d = '{pos: player_pos[2], colour: colour_p3};
      cmd_p4:    pixel_d = '{pos: player_pos[3], colour: colour_p4};
      cmd_timer: pixel_d = '{pos: '{x: bar_x, y: timer_row}, colour: colour_white};
      default:   plot_d  = 1'b0; // Hold, step and none plot nothing
    endcase
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (plot_d)
      pixel <= pixel_d;
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n)
  begin
    if (!rst_n)
      plot <= 1'b0;
    else
      plot <= plot_d;
  end

  // Sweep pixel strobe is followed by four quiet cycles
  a_sweep_spacing: assert property (
    @(posedge CLOCK_50) disable iff (!rst_n)
    cmd == cmd_clear_plot |=> plot ##1 !plot [*4]
  );

endmodule

/* design/turf_pkg.sv */
package turf_pkg;

  // Screen position, x in the upper bits so {x, y} forms the sweep address
  typedef struct packed {
    logic [7:0] x;
    logic [6:0] y;
  } coord_t;

  typedef struct packed {
    coord_t     pos;
    logic [2:0] colour;
  } pixel_t;

  typedef enum logic [3:0] {
    idle, clear_plot, clear_hold, clear_step,
    draw_p1, draw_p2, draw_p3, draw_p4, draw_timer,
    end_plot, end_hold, end_step,
    game_over
  } game_state_e;

  typedef enum logic [3:0] {
    cmd_none, cmd_clear_plot, cmd_clear_hold, cmd_clear_step,
    cmd_p1, cmd_p2, cmd_p3, cmd_p4,
    cmd_timer
  } plot_cmd_e;

  localparam logic [7:0] screen_x_max = 8'd159;
  localparam logic [6:0] screen_y_max = 7'd127; // Rows 120 up are off screen
  localparam logic [6:0] timer_row    = 7'd119;
  localparam logic [7:0] timer_last_x = 8'd158;

  // Last address of a sweep
  localparam coord_t sweep_last = '{x: screen_x_max, y: screen_y_max};

  localparam int clear_hold_cycles = 2;
  localparam int hold_w            = $clog2(clear_hold_cycles + 1);

  localparam logic [4:0] key_space = 5'd16;

  localparam logic [2:0] colour_black = 3'b000;
  localparam logic [2:0] colour_white = 3'b111;
  localparam logic [2:0] colour_p1    = 3'b001;
  localparam logic [2:0] colour_p2    = 3'b010;
  localparam logic [2:0] colour_p3    = 3'b100;
  localparam logic [2:0] colour_p4    = 3'b110;

endpackage

/* design/turf_wars.sv */
module turf_wars
  import turf_pkg::*;
(
  input  logic             CLOCK_50,
  input  logic             rst_n,
  input  logic       [4:0] key_code,
  input  coord_t     [3:0] player_pos,
  input  logic             timer_tick,
  output pixel_t           pixel,
  output logic             plot,
  output logic             game_started,
  output logic             running
);

  plot_cmd_e  cmd;
  logic       sweep_white;
  logic       sweep_done;
  logic       hold_done;
  logic [7:0] bar_x;

  turf_game_fsm i_game_fsm (
    .CLOCK_50     (CLOCK_50),
    .rst_n        (rst_n),
    .key_code     (key_code),
    .running      (running),
    .sweep_done   (sweep_done),
    .hold_done    (hold_done),
    .cmd          (cmd),
    .sweep_white  (sweep_white),
    .game_started (game_started)
  );

  turf_pixel_unit i_pixel_unit (
    .CLOCK_50    (CLOCK_50),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .sweep_white (sweep_white),
    .player_pos  (player_pos),
    .bar_x       (bar_x),
    .pixel       (pixel),
    .plot        (plot),
    .sweep_done  (sweep_done),
    .hold_done   (hold_done)
  );

  turf_game_timer i_game_timer (
    .CLOCK_50     (CLOCK_50),
    .rst_n        (rst_n),
    .timer_tick   (timer_tick),
    .game_started (game_started),
    .bar_x        (bar_x),
    .running      (running)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module tb_turf_wars \
  -f turf_wars.f \
  -o tb_turf_wars

./obj_dir/tb_turf_wars | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb/tb_turf_wars.sv */
module tb_turf_wars
  import turf_pkg::*;
();

  localparam int reset_cycles = 8;
  localparam int sweep_len    = (int'(screen_x_max) + 1) * (int'(screen_y_max) + 1)
                                * (clear_hold_cycles + 3);
  localparam int game_len     = (int'(timer_last_x) + 1) * 32; // One tick in 32 cycles
  localparam int tail_cycles  = 200;                          // Quiet check after game over
  // Two sweeps, the game, and margin
  localparam int timeout_cycles = 2 * sweep_len + game_len + 90000;

  logic             CLOCK_50   = 1'b0;
  logic             rst_n      = 1'b0;
  logic       [4:0] key_code   = 5'd0;
  coord_t     [3:0] player_pos = '0;
  logic             timer_tick = 1'b0;
  logic             end_test   = 1'b0;

  pixel_t pixel;
  logic   plot;
  logic   game_started;
  logic   running;

  int     mismatch_count;
  int     other_count;
  logic   game_over_seen;
  logic   report_done;

  logic [16:0] lfsr        = 17'd85989;
  int          cycle_cnt   = 0;
  int          start_cycle = 0;
  int          tail_cnt    = 0;

  always #4 CLOCK_50 = ~CLOCK_50;

  turf_wars i_turf_wars (
    .CLOCK_50     (CLOCK_50),
    .rst_n        (rst_n),
    .key_code     (key_code),
    .player_pos   (player_pos),
    .timer_tick   (timer_tick),
    .pixel        (pixel),
    .plot         (plot),
    .game_started (game_started),
    .running      (running)
  );

  turf_checker i_turf_checker (
    .CLOCK_50       (CLOCK_50),
    .rst_n          (rst_n),
    .key_code       (key_code),
    .player_pos     (player_pos),
    .timer_tick     (timer_tick),
    .pixel          (pixel),
    .plot           (plot),
    .game_started   (game_started),
    .running        (running),
    .end_test       (end_test),
    .mismatch_count (mismatch_count),
    .other_count    (other_count),
    .game_over_seen (game_over_seen),
    .report_done    (report_done)
  );

  // Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    lfsr_step = {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]}; // One step per bit
    end
  endtask

  task automatic drive_stimulus();
    logic   [31:0] bits;
    logic   [4:0]  key;
    coord_t [3:0]  pos_next;
    int            p;
    if (cycle_cnt == reset_cycles)
    begin
      rst_n <= 1'b1;
      take_bits(8, bits);
      start_cycle = cycle_cnt + 16 + int'(bits[7:0]); // Random idle delay
    end
    take_bits(5, bits);
    key = bits[4:0];
    if (key == key_space)
      key = key ^ 5'd1;
    if (cycle_cnt == start_cycle)
      key = key_space;
    if (game_over_seen)
    begin
      tail_cnt = tail_cnt + 1;
      if (tail_cnt % 8 == 0)
        key = key_space; // Space again, must be ignored
      if (tail_cnt == tail_cycles)
        end_test <= 1'b1;
    end
    key_code <= key;
    for (p = 0; p < 4; p++)
    begin
      take_bits(8, bits);
      pos_next[p[1:0]].x = bits[7:0];
      take_bits(7, bits);
      pos_next[p[1:0]].y = bits[6:0];
    end
    player_pos <= pos_next;
    take_bits(5, bits);
    timer_tick <= (bits[4:0] == 5'd0);
  endtask

  task automatic print_counts();
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
  endtask

  always @(posedge CLOCK_50)
  begin
    if (report_done)
    begin
      print_counts();
      if (mismatch_count == 0 && other_count == 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
      $finish;
    end
    else if (cycle_cnt >= timeout_cycles)
    begin
      $display("Timeout: the game did not end within %0d cycles", cycle_cnt);
      print_counts();
      $display("TESTS FAILED");
      $finish;
    end
    else
    begin
      cycle_cnt = cycle_cnt + 1;
      drive_stimulus();
    end
  end

endmodule

/* tb/turf_checker.sv */
module turf_checker
  import turf_pkg::*;
(
  input  logic             CLOCK_50,
  input  logic             rst_n,
  input  logic       [4:0] key_code,
  input  coord_t     [3:0] player_pos,
  input  logic             timer_tick,
  input  pixel_t           pixel,
  input  logic             plot,
  input  logic             game_started,
  input  logic             running,
  input  logic             end_test,
  output int               mismatch_count,
  output int               other_count,
  output logic             game_over_seen,
  output logic             report_done
);

  typedef enum logic [2:0] {
    ph_idle, ph_sweep_black, ph_game, ph_sweep_white, ph_over
  } phase_e;

  localparam int rows         = int'(screen_y_max) + 1;
  localparam int sweep_pixels = (int'(screen_x_max) + 1) * rows;
  localparam int pixel_cycles = clear_hold_cycles + 3; // Plot, hold, step
  localparam int max_lines    = 20;

  phase_e     phase;
  int         sub;       // Cycle within a sweep pixel
  int         addr;
  logic [2:0] slot;      // Position in the game frame
  logic [7:0] bar;
  logic       run;
  logic       seen;
  logic       exp_plot;  // Expected on the next cycle
  pixel_t     exp_pix;
  logic [1:0] exp_sweep; // 1 black, 2 white
  logic       exp_timer; // Timer pixel closes a frame
  int         black_ok;
  int         white_ok;
  int         frames;

  function automatic logic [2:0] player_colour(input logic [1:0] idx);
    case (idx)
      2'd0:    player_colour = colour_p1;
      2'd1:    player_colour = colour_p2;
      2'd2:    player_colour = colour_p3;
      default: player_colour = colour_p4;
    endcase
  endfunction

  task automatic report_bit(input string name, input logic got, input logic want);
    mismatch_count = mismatch_count + 1;
    if (mismatch_count <= max_lines)
      $display("MISMATCH at %0t: %s is %0b, expected %0b", $time, name, got, want);
  endtask

  task automatic report_pixel();
    mismatch_count = mismatch_count + 1;
    if (mismatch_count <= max_lines)
      $display("MISMATCH at %0t: pixel (%0d,%0d) colour %0d, expected (%0d,%0d) colour %0d",
               $time, pixel.pos.x, pixel.pos.y, pixel.colour,
               exp_pix.pos.x, exp_pix.pos.y, exp_pix.colour);
  endtask

  task automatic reset_model();
    phase          = ph_idle;
    sub            = 0;
    addr           = 0;
    slot           = 3'd0;
    bar            = 8'd0;
    run            = 1'b0;
    seen           = 1'b0;
    exp_plot       = 1'b0;
    exp_pix        = '0;
    exp_sweep      = 2'd0;
    exp_timer      = 1'b0;
    black_ok       = 0;
    white_ok       = 0;
    frames         = 0;
    mismatch_count = 0;
    other_count    = 0;
    game_over_seen = 1'b0;
    report_done    = 1'b0;
  endtask

  task automatic compare_outputs();
    logic started_exp;
    started_exp = phase inside {ph_game, ph_sweep_white, ph_over};
    if (plot !== exp_plot)
      report_bit("plot", plot, exp_plot);
    else if (exp_plot && pixel !== exp_pix)
      report_pixel();
    else if (exp_plot && exp_sweep == 2'd1)
      black_ok = black_ok + 1;
    else if (exp_plot && exp_sweep == 2'd2)
      white_ok = white_ok + 1;
    else if (exp_plot && exp_timer)
      frames = frames + 1;
    if (game_started !== started_exp)
      report_bit("game_started", game_started, started_exp);
    if (running !== run)
      report_bit("running", running, run);
  endtask

  task automatic advance_model();
    logic       started_now;
    logic       old_run;
    logic [7:0] old_bar;
    started_now = phase inside {ph_game, ph_sweep_white, ph_over};
    old_run     = run;
    old_bar     = bar;

    // Pixel registered from this cycle's command
    exp_plot  = 1'b0;
    exp_sweep = 2'd0;
    exp_timer = 1'b0;
    if ((phase == ph_sweep_black || phase == ph_sweep_white) && sub == 0)
    begin
      exp_plot       = 1'b1;
      exp_pix.pos.x  = 8'(addr / rows);    // x outer
      exp_pix.pos.y  = 7'(addr % rows);    // y inner
      exp_pix.colour = (phase == ph_sweep_white) ? colour_white : colour_black;
      exp_sweep      = (phase == ph_sweep_white) ? 2'd2 : 2'd1;
    end
    else if (phase == ph_game)
    begin
      exp_plot = 1'b1;
      if (slot == 3'd4)
      begin
        exp_pix   = '{pos: '{x: old_bar, y: timer_row}, colour: colour_white};
        exp_timer = 1'b1;
      end
      else
        exp_pix = '{pos: player_pos[slot[1:0]], colour: player_colour(slot[1:0])};
    end

    // Game timer
    if (started_now)
    begin
      if (!seen)
        run = 1'b1;
      seen = 1'b1;
      if (timer_tick)
      begin
        bar = old_bar + 8'd1;
        if (old_bar >= timer_last_x)
          run = 1'b0;
      end
    end

    case (phase)
      ph_idle:
      begin
        if (key_code == key_space)
        begin
          phase = ph_sweep_black;
          sub   = 0;
          addr  = 0;
        end
      end
      ph_sweep_black,
      ph_sweep_white:
      begin
        if (sub < pixel_cycles - 1)
          sub = sub + 1;
        else if (addr == sweep_pixels - 1)
        begin
          phase = (phase == ph_sweep_black) ? ph_game : ph_over;
          slot  = 3'd0;
        end
        else
        begin
          addr = addr + 1;
          sub  = 0;
        end
      end
      ph_game:
      begin
        if (slot < 3'd4)
          slot = slot + 3'd1;
        else
        begin
          slot = 3'd0;
          if (!old_run)
          begin
            phase = ph_sweep_white; // Frame done after the timer ran out
            sub   = 0;
            addr  = 0;
          end
        end
      end
      default: ;
    endcase
    game_over_seen = (phase == ph_over);
  endtask

  task automatic final_checks();
    if (black_ok != sweep_pixels)
    begin
      other_count = other_count + 1;
      $display("Start sweep incomplete: %0d of %0d black pixels plotted", black_ok, sweep_pixels);
    end
    if (white_ok != sweep_pixels)
    begin
      other_count = other_count + 1;
      $display("End sweep incomplete: %0d of %0d white pixels plotted", white_ok, sweep_pixels);
    end
    if (frames == 0)
    begin
      other_count = other_count + 1;
      $display("No game frame was plotted");
    end
    report_done = 1'b1;
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge CLOCK_50)
  begin
    if (!rst_n)
      reset_model();
    else
    begin
      compare_outputs();
      advance_model();
      if (end_test && !report_done)
        final_checks();
    end
  end

endmodule

/* turf_wars.f */
design/turf_pkg.sv
design/turf_game_fsm.sv
design/turf_pixel_unit.sv
design/turf_game_timer.sv
design/turf_wars.sv
tb/turf_checker.sv
tb/tb_turf_wars.sv
